// File: compile.f
cpu_pkg.sv
exec_if.sv
reg_file.sv
instr_decoder.sv
alu_stage.sv
cpu_core.sv
cpu_core_checker.sv
cpu_core_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module cpu_core_tb \
	-o cpu_core_sim > build.log 2>&1 \
	&& ./obj_dir/cpu_core_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// File: cpu_core_tb.sv
module cpu_core_tb;
	import cpu_pkg::*;

	localparam int PERIOD    = 100;
	localparam int NUM_INSTR = 14;

	logic       clk;
	logic       rst;
	logic       req;
	instr_t     instr;
	logic       ack;
	logic       result_valid;
	reg_addr_t  result_addr;
	reg_value_t result_value;
	reg_value_t debug_out;

	// Reference register model and expected results in issue order
	reg_value_t model [16];
	reg_addr_t  exp_addr_q [$];
	reg_value_t exp_value_q [$];
	int         sent_count;
	int         results_seen;
	int         value_errors;
	int         other_errors;
	int         seed;

	cpu_core cpu_core_i (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.instr        (instr),
		.ack          (ack),
		.result_valid (result_valid),
		.result_addr  (result_addr),
		.result_value (result_value),
		.debug_out    (debug_out)
	);

	always #(PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(string name, reg_value_t got, reg_value_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic compare_addr(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Drive and sample just after the rising edge
	task automatic step();
		@(posedge clk);
		#10;
	endtask

	function automatic instr_t make_instr(opcode_t op, int rd, int rs1, int rs2,
		logic [7:0] imm);
		instr_t in;
		in.op  = op;
		in.rd  = reg_addr_t'(rd);
		in.rs1 = reg_addr_t'(rs1);
		in.rs2 = reg_addr_t'(rs2);
		in.imm = imm;
		return in;
	endfunction

	function automatic logic [7:0] random_imm();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic reg_value_t predict(instr_t in);
		reg_value_t a;
		reg_value_t b;
		reg_value_t y;
		a = model[in.rs1];
		b = model[in.rs2];
		case (in.op)
			OP_ADD:  y = a + b;
			OP_SUB:  y = a - b;
			OP_AND:  y = a & b;
			OP_OR:   y = a | b;
			OP_XOR:  y = a ^ b;
			OP_LI:   y = {8'h00, in.imm};
			default: y = '0;
		endcase
		return y;
	endfunction

	// Result monitor samples mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			if (exp_addr_q.size() == 0) begin
				$display("ERROR at %0t: a result appeared with no instruction pending", $time);
				other_errors++;
			end else begin
				compare_addr("result_addr", result_addr, exp_addr_q.pop_front());
				compare_value("result_value", result_value, exp_value_q.pop_front());
			end
			results_seen++;
		end
	end

	// Four-phase send; hold keeps req high for extra cycles after ack
	task automatic send_instr(instr_t in, int hold, bit wait_result);
		reg_value_t exp;
		int cycles;
		exp = predict(in);
		exp_addr_q.push_back(in.rd);
		exp_value_q.push_back(exp);
		if (in.rd != ZERO_REG) begin
			model[in.rd] = exp;
		end
		sent_count++;
		instr = in;
		req = 1'b1;
		cycles = 0;
		step();
		while (!ack && cycles < 10) begin
			step();
			cycles++;
		end
		if (!ack) begin
			$display("ERROR at %0t: ack never rose for a request", $time);
			other_errors++;
		end
		repeat (hold) begin
			step();
			compare_bit("ack", ack, 1'b1);
		end
		req = 1'b0;
		step();
		compare_bit("ack", ack, 1'b0);
		if (wait_result) begin
			cycles = 0;
			while (results_seen != sent_count && cycles < 10) begin
				step();
				cycles++;
			end
			if (results_seen != sent_count) begin
				$display("ERROR at %0t: result_valid never arrived", $time);
				other_errors++;
			end
			compare_value("debug_out", debug_out, model[DEBUG_REG]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_state();
		compare_bit("ack", ack, 1'b0);
		compare_bit("result_valid", result_valid, 1'b0);
		compare_value("debug_out", debug_out, '0);
		send_instr(make_instr(OP_ADD, 1, 0, 0, 8'h00), 0, 1'b1);
	endtask

	task automatic opcode_sweep();
		send_instr(make_instr(OP_LI, 5, 0, 0, random_imm()), 0, 1'b1);
		send_instr(make_instr(OP_LI, 6, 0, 0, random_imm()), 0, 1'b1);
		for (int i = 0; i < 5; i++) begin
			send_instr(make_instr(opcode_t'(i), 1, 5, 6, 8'h00), 0, 1'b1);
		end
	endtask

	// Dependent chain at the fastest handshake rate
	task automatic forwarding_chain();
		send_instr(make_instr(OP_LI, 2, 0, 0, random_imm()), 0, 1'b0);
		send_instr(make_instr(OP_ADD, 3, 2, 2, 8'h00), 0, 1'b0);
		send_instr(make_instr(OP_XOR, 4, 3, 2, 8'h00), 0, 1'b1);
	endtask

	// ADD reads r0 while the LI into r0 sits in writeback
	task automatic zero_register();
		send_instr(make_instr(OP_LI, 0, 0, 0, random_imm()), 0, 1'b0);
		send_instr(make_instr(OP_ADD, 8, 0, 0, 8'h00), 0, 1'b1);
	endtask

	task automatic held_request();
		send_instr(make_instr(OP_OR, 9, 5, 6, 8'h00), 4, 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		instr = '0;
		seed = 10214;
		sent_count = 0;
		results_seen = 0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < 16; i++) begin
			model[i] = '0;
		end
		repeat (16) @(posedge clk);
		#10;
		rst = 1'b0;
		reset_state();
		opcode_sweep();
		forwarding_chain();
		zero_register();
		held_request();
		repeat (4) step();
		if (exp_addr_q.size() != 0) begin
			$display("ERROR: %0d results never arrived", exp_addr_q.size());
			other_errors++;
		end
		$display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((NUM_INSTR * 20 + 100) * PERIOD);
		$display("ERROR: watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

endmodule

// File: cpu_core_checker.sv
module cpu_core_checker (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic result_valid
);

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	// Four-phase rule, ack held until req drops
	ack_holds: assert property (@(posedge clk) disable iff (rst)
		(ack && req) |=> ack)
		else $error("ack fell while req was still high");

	// Writeback one edge after the ack edge
	result_follows_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |=> $rose(result_valid))
		else $error("result_valid did not follow ack");

	result_has_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(result_valid) |-> ($past(ack) && !$past(ack, 2)))
		else $error("result_valid without a matching ack");

	// Issue rate is at most one per two cycles
	result_pulse: assert property (@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid)
		else $error("result_valid high for more than one cycle");

endmodule

bind cpu_core cpu_core_checker cpu_core_checker_i (
	.clk          (clk),
	.rst          (rst),
	.req          (req),
	.ack          (ack),
	.result_valid (result_valid)
);

// File: cpu_core.sv
module cpu_core (
	input  logic                clk,
	input  logic                rst,

	input  logic                req,
	input  cpu_pkg::instr_t     instr,
	output logic                ack,

	output logic                result_valid,
	output cpu_pkg::reg_addr_t  result_addr,
	output cpu_pkg::reg_value_t result_value,

	output cpu_pkg::reg_value_t debug_out
);
	import cpu_pkg::*;

	localparam int NUM_REGS = 16;

	reg_addr_t  read_addr1;
	reg_addr_t  read_addr2;
	reg_value_t read_value1;
	reg_value_t read_value2;

	// Result being computed this cycle
	logic       alu_write;
	reg_addr_t  alu_addr;
	reg_value_t alu_value;

	exec_if exec_bus ();

	instr_decoder #(
		.NUM_REGS (NUM_REGS)
	) instr_decoder_i (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.instr       (instr),
		.ack         (ack),
		.read_addr1  (read_addr1),
		.read_addr2  (read_addr2),
		.read_value1 (read_value1),
		.read_value2 (read_value2),
		.issue       (exec_bus.issue)
	);

	reg_file #(
		.NUM_REGS (NUM_REGS)
	) reg_file_i (
		.clk         (clk),
		.rst         (rst),
		.wb_write    (result_valid),
		.wb_addr     (result_addr),
		.wb_value    (result_value),
		.alu_write   (alu_write),
		.alu_addr    (alu_addr),
		.alu_value   (alu_value),
		.read_addr1  (read_addr1),
		.read_addr2  (read_addr2),
		.read_value1 (read_value1),
		.read_value2 (read_value2),
		.debug_out   (debug_out)
	);

	// Writeback group doubles as the result outputs
	alu_stage alu_stage_i (
		.clk       (clk),
		.rst       (rst),
		.execute   (exec_bus.execute),
		.alu_write (alu_write),
		.alu_addr  (alu_addr),
		.alu_value (alu_value),
		.wb_write  (result_valid),
		.wb_addr   (result_addr),
		.wb_value  (result_value)
	);

endmodule

// File: alu_stage.sv
module alu_stage (
	input  logic                clk,
	input  logic                rst,

	exec_if.execute             execute,

	output logic                alu_write,
	output cpu_pkg::reg_addr_t  alu_addr,
	output cpu_pkg::reg_value_t alu_value,

	output logic                wb_write,
	output cpu_pkg::reg_addr_t  wb_addr,
	output cpu_pkg::reg_value_t wb_value
);
	import cpu_pkg::*;

	reg_value_t result;

	//////////////////////////////////////////////////////////////////////
	// Arithmetic
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (execute.op)
			OP_ADD:  result = execute.a + execute.b;
			OP_SUB:  result = execute.a - execute.b;
			OP_AND:  result = execute.a & execute.b;
			OP_OR:   result = execute.a | execute.b;
			OP_XOR:  result = execute.a ^ execute.b;
			// Immediate already placed in operand a
			OP_LI:   result = execute.a;
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Execute and writeback registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			alu_write <= 1'b0;
			wb_write  <= 1'b0;
		end else begin
			alu_write <= execute.valid;
			wb_write  <= alu_write;
		end
	end

	// Payload follows the valid bits; r0 writes are dropped in the register file
	always_ff @(posedge clk) begin
		alu_addr  <= execute.rd;
		alu_value <= result;
		wb_addr   <= alu_addr;
		wb_value  <= alu_value;
	end

endmodule

// File: instr_decoder.sv
module instr_decoder #(
	parameter int NUM_REGS = 16
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                req,
	input  cpu_pkg::instr_t     instr,
	output logic                ack,

	output cpu_pkg::reg_addr_t  read_addr1,
	output cpu_pkg::reg_addr_t  read_addr2,
	input  cpu_pkg::reg_value_t read_value1,
	input  cpu_pkg::reg_value_t read_value2,

	exec_if.issue               issue
);
	import cpu_pkg::*;

	typedef enum logic {
		IDLE,
		WAIT_RELEASE
	} state_t;

	state_t state;
	state_t state_next;

	logic accept;
	logic is_li;
	logic rd_ok;
	logic rs_ok;

	//////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_next = WAIT_RELEASE;
				end
			end
			WAIT_RELEASE: begin
				// Hold ack until the source drops req
				if (!req) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign ack    = (state == WAIT_RELEASE);
	assign accept = (state == IDLE) && req;

	//////////////////////////////////////////////////////////////////////
	// Operand read and issue
	//////////////////////////////////////////////////////////////////////

	assign is_li = (instr.op == OP_LI);

	// Sources only matter when they are actually read
	assign rd_ok = int'(instr.rd) < NUM_REGS;
	assign rs_ok = is_li || ((int'(instr.rs1) < NUM_REGS) && (int'(instr.rs2) < NUM_REGS));

	assign read_addr1 = instr.rs1;
	assign read_addr2 = instr.rs2;

	// Out-of-range instructions still get acked, just never issued
	assign issue.valid = accept && rd_ok && rs_ok;
	assign issue.op    = instr.op;
	assign issue.rd    = instr.rd;
	assign issue.a     = is_li ? reg_value_t'(instr.imm) : read_value1;
	assign issue.b     = read_value2;

endmodule

// File: reg_file.sv
module reg_file #(
	parameter int NUM_REGS = 16
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                wb_write,
	input  cpu_pkg::reg_addr_t  wb_addr,
	input  cpu_pkg::reg_value_t wb_value,

	input  logic                alu_write,
	input  cpu_pkg::reg_addr_t  alu_addr,
	input  cpu_pkg::reg_value_t alu_value,

	input  cpu_pkg::reg_addr_t  read_addr1,
	input  cpu_pkg::reg_addr_t  read_addr2,
	output cpu_pkg::reg_value_t read_value1,
	output cpu_pkg::reg_value_t read_value2,

	output cpu_pkg::reg_value_t debug_out
);
	import cpu_pkg::*;

	reg_value_t regs [NUM_REGS];

	// Both read ports handled by one loop
	reg_addr_t  port_addr  [2];
	reg_value_t port_value [2];

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Writeback lands on the rising edge; r0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write && (wb_addr != ZERO_REG) && (int'(wb_addr) < NUM_REGS)) begin
			regs[wb_addr] <= wb_value;
		end
	end

	assign debug_out = regs[DEBUG_REG];

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	assign port_addr[0] = read_addr1;
	assign port_addr[1] = read_addr2;

	// Priority: ALU result, then writeback, then stored value
	for (genvar p = 0; p < 2; p++) begin : g_read
		always_comb begin
			if (port_addr[p] == ZERO_REG) begin
				port_value[p] = '0;
			end else if (alu_write && (alu_addr == port_addr[p])) begin
				port_value[p] = alu_value;
			end else if (wb_write && (wb_addr == port_addr[p])) begin
				port_value[p] = wb_value;
			end else if (int'(port_addr[p]) < NUM_REGS) begin
				port_value[p] = regs[port_addr[p]];
			end else begin
				// Beyond the file in a reduced configuration
				port_value[p] = '0;
			end
		end
	end

	assign read_value1 = port_value[0];
	assign read_value2 = port_value[1];

endmodule

// File: exec_if.sv
interface exec_if;
	import cpu_pkg::*;

	// One-cycle issue pulse, no back-pressure
	logic       valid;
	opcode_t    op;
	reg_value_t a;
	reg_value_t b;
	reg_addr_t  rd;

	// Decoder side
	modport issue (
		output valid,
		output op,
		output a,
		output b,
		output rd
	);

	// ALU stage side
	modport execute (
		input valid,
		input op,
		input a,
		input b,
		input rd
	);

endinterface

// File: cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int ADDR_WIDTH  = 4;
	localparam int VALUE_WIDTH = 16;
	localparam int IMM_WIDTH   = 8;

	typedef logic [ADDR_WIDTH-1:0]  reg_addr_t;
	typedef logic [VALUE_WIDTH-1:0] reg_value_t;

	//////////////////////////////////////////////////////////////////////
	// Instruction format
	//////////////////////////////////////////////////////////////////////

	// ALU operations, plus load-immediate
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_LI
	} opcode_t;

	// 23 bits, op in the top bits
	typedef struct packed {
		opcode_t               op;
		reg_addr_t             rd;
		reg_addr_t             rs1;
		reg_addr_t             rs2;
		logic [IMM_WIDTH-1:0]  imm;
	} instr_t;

	// Hard-wired zero register
	localparam reg_addr_t ZERO_REG  = reg_addr_t'(0);
	// Register shown on the debug output
	localparam reg_addr_t DEBUG_REG = reg_addr_t'(1);

endpackage
